//--- source/fsa_pkg.sv
package fsa_pkg;

	// image geometry.
	localparam int pixel_width = 8;
	localparam int img_hw = 12;
	localparam int img_ww = 12;

	// the column buffer keeps one word per image column.
	localparam int br_aw = img_ww;
	localparam int br_dw = 32;
	localparam int br_num = 4;
	localparam int bank_w = 2;

	// a buffer word holds {zero, valid, top row, bottom row}.
	localparam int bot_lsb = 0;
	localparam int top_lsb = bot_lsb + img_hw;
	localparam int val_bit = top_lsb + img_hw;

	// request register, ram read and output register.
	localparam int rd_latency = 3;

	// tag carried with each read slot so the data returns to its requester.
	typedef enum logic [1:0] {
		owner_none,
		owner_core,
		owner_host
	} owner_t;

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_wait,
		st_done
	} readout_state_t;

endpackage

//--- source/column_buffer.sv
`timescale 1ns/1ns

module column_buffer (
	input  logic                       clk,
	input  logic [fsa_pkg::br_num-1:0] wr_en,
	input  logic [fsa_pkg::br_aw-1:0]  wr_addr,
	input  logic [fsa_pkg::br_dw-1:0]  wr_data,
	input  logic                       buf_rd_en,
	input  logic [fsa_pkg::bank_w-1:0] buf_rd_bank,
	input  logic [fsa_pkg::br_aw-1:0]  buf_rd_addr,
	output logic [fsa_pkg::br_dw-1:0]  buf_rd_data
);
	import fsa_pkg::*;

	logic [br_dw-1:0]  mem [br_num][2**br_aw];
	logic [br_dw-1:0]  rd_q [br_num];
	logic [bank_w-1:0] sel_q;

	// every bank in the mask takes the same word, so one frame can fill several banks.
	always_ff @(posedge clk) begin
		for (int b = 0; b < br_num; b++) begin
			if (wr_en[b]) begin
				mem[b][wr_addr] <= wr_data;
			end
			if (buf_rd_en && buf_rd_bank == bank_w'(b)) begin
				rd_q[b] <= mem[b][buf_rd_addr];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (buf_rd_en) begin
			sel_q <= buf_rd_bank;
		end
	end

	// the bank select follows the read so the output names the bank just read.
	assign buf_rd_data = rd_q[sel_q];

endmodule

//--- source/buffer_read_arbiter.sv
`timescale 1ns/1ns

module buffer_read_arbiter (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic [fsa_pkg::bank_w-1:0] scan_bank,
	input  logic                       core_rd_en,
	input  logic [fsa_pkg::br_aw-1:0]  core_rd_addr,
	input  logic                       host_req,
	input  logic [fsa_pkg::bank_w-1:0] host_bank,
	input  logic [fsa_pkg::br_aw-1:0]  host_addr,
	output logic [fsa_pkg::br_dw-1:0]  core_rd_data,
	output logic                       host_grant,
	output logic [fsa_pkg::br_dw-1:0]  host_rd_data,
	output logic                       buf_rd_en,
	output logic [fsa_pkg::bank_w-1:0] buf_rd_bank,
	output logic [fsa_pkg::br_aw-1:0]  buf_rd_addr,
	input  logic [fsa_pkg::br_dw-1:0]  buf_rd_data
);
	import fsa_pkg::*;

	owner_t req_owner;
	owner_t ram_owner;

	// the stream never waits, so the host only gets the slots the core leaves free.
	assign host_grant = host_req && !core_rd_en;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			buf_rd_en <= 1'b0;
			req_owner <= owner_none;
			ram_owner <= owner_none;
		end else begin
			buf_rd_en <= core_rd_en || host_grant;
			ram_owner <= req_owner;
			if (core_rd_en) begin
				req_owner <= owner_core;
			end else if (host_grant) begin
				req_owner <= owner_host;
			end else begin
				req_owner <= owner_none;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (core_rd_en) begin
			buf_rd_addr <= core_rd_addr;
			buf_rd_bank <= scan_bank;
		end else if (host_grant) begin
			buf_rd_addr <= host_addr;
			buf_rd_bank <= host_bank;
		end
	end

	// ram_owner lines up with the word now leaving the buffer.
	always_ff @(posedge clk) begin
		if (ram_owner == owner_core) begin
			core_rd_data <= buf_rd_data;
		end
		if (ram_owner == owner_host) begin
			host_rd_data <= buf_rd_data;
		end
	end

endmodule

//--- source/fsa_core.sv
`timescale 1ns/1ns

module fsa_core (
	input  logic                            clk,
	input  logic                            resetn,
	input  logic [fsa_pkg::img_hw-1:0]      height,
	input  logic [fsa_pkg::img_ww-1:0]      width,
	input  logic [fsa_pkg::br_num-1:0]      bank_mask,
	input  logic [fsa_pkg::pixel_width-1:0] ref_data,
	input  logic                            s_axis_tvalid,
	input  logic [fsa_pkg::pixel_width-1:0] s_axis_tdata,
	input  logic                            s_axis_tuser,
	input  logic                            s_axis_tlast,
	output logic                            s_axis_tready,
	output logic                            sof,
	output logic [fsa_pkg::img_ww-1:0]      lft_v,
	output logic [fsa_pkg::img_ww-1:0]      rt_v,
	output logic                            core_rd_en,
	output logic [fsa_pkg::br_aw-1:0]       core_rd_addr,
	output logic [fsa_pkg::br_num-1:0]      wr_en,
	output logic [fsa_pkg::br_aw-1:0]       wr_addr,
	output logic [fsa_pkg::br_dw-1:0]       wr_data,
	input  logic [fsa_pkg::br_dw-1:0]       core_rd_data
);
	import fsa_pkg::*;

	logic              accept;
	logic [br_aw-1:0]  col_next;
	logic [img_ww-1:0] width_m1;
	logic [img_hw-1:0] height_m1;

	logic              dark_p0;
	logic              row_end_p0;
	logic              first_row_p0;
	logic [img_hw-1:0] y_p0;

	logic              vld_p1;
	logic              dark_p1;
	logic              row_end_p1;
	logic              first_row_p1;
	logic              last_row_p1;
	logic [br_aw-1:0]  x_p1;
	logic [img_hw-1:0] y_p1;

	logic              vld_p2;
	logic              dark_p2;
	logic              frame_end_p2;
	logic              first_row_p2;
	logic              last_row_p2;
	logic [br_aw-1:0]  x_p2;
	logic [img_hw-1:0] y_p2;

	logic              vld_p3;
	logic              dark_p3;
	logic              frame_end_p3;
	logic              first_row_p3;
	logic              last_row_p3;
	logic [br_aw-1:0]  x_p3;
	logic [img_hw-1:0] y_p3;

	logic              old_val;
	logic [img_hw-1:0] old_top;
	logic [img_hw-1:0] old_bot;
	logic              ent_val;
	logic [img_hw-1:0] ent_top;
	logic [img_hw-1:0] ent_bot;

	logic              lft_done;
	logic [img_ww-1:0] lft_edge;
	logic              rt_prev;
	logic [img_ww-1:0] rt_edge;

	assign s_axis_tready = 1'b1;
	assign accept = s_axis_tvalid && s_axis_tready;
	assign width_m1 = width - 1'b1;
	assign height_m1 = height - 1'b1;

	// column of the pixel being accepted.
	assign col_next = (s_axis_tuser || row_end_p0) ? '0 : core_rd_addr + 1'b1;

	// stage 0 issues the read of the column entry for the accepted pixel.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			core_rd_en <= 1'b0;
			core_rd_addr <= '0;
			row_end_p0 <= 1'b0;
			first_row_p0 <= 1'b0;
			y_p0 <= '0;
		end else begin
			core_rd_en <= accept;
			if (accept) begin
				core_rd_addr <= col_next;
				row_end_p0 <= s_axis_tlast || (col_next == width_m1);
				if (s_axis_tuser) begin
					y_p0 <= '0;
					first_row_p0 <= 1'b1;
				end else if (row_end_p0) begin
					y_p0 <= y_p0 + 1'b1;
					first_row_p0 <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dark_p0 <= s_axis_tdata < ref_data;
		end
	end

	// stages 1 to 3 hold the pixel while the entry comes back from the buffer.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			vld_p1 <= 1'b0;
			vld_p2 <= 1'b0;
			vld_p3 <= 1'b0;
			row_end_p1 <= 1'b0;
			frame_end_p2 <= 1'b0;
			frame_end_p3 <= 1'b0;
			first_row_p1 <= 1'b0;
			first_row_p2 <= 1'b0;
			first_row_p3 <= 1'b0;
			last_row_p1 <= 1'b0;
			last_row_p2 <= 1'b0;
			last_row_p3 <= 1'b0;
		end else begin
			vld_p1 <= core_rd_en;
			vld_p2 <= vld_p1;
			vld_p3 <= vld_p2;
			row_end_p1 <= row_end_p0;
			frame_end_p2 <= row_end_p1 && last_row_p1;
			frame_end_p3 <= vld_p2 && frame_end_p2;
			first_row_p1 <= first_row_p0;
			first_row_p2 <= first_row_p1;
			first_row_p3 <= first_row_p2;
			last_row_p1 <= (y_p0 == height_m1);
			last_row_p2 <= last_row_p1;
			last_row_p3 <= last_row_p2;
		end
	end

	always_ff @(posedge clk) begin
		dark_p1 <= dark_p0;
		dark_p2 <= dark_p1;
		dark_p3 <= dark_p2;
		x_p1 <= core_rd_addr;
		x_p2 <= x_p1;
		x_p3 <= x_p2;
		y_p1 <= y_p0;
		y_p2 <= y_p1;
		y_p3 <= y_p2;
	end

	assign old_val = core_rd_data[val_bit];
	assign old_top = core_rd_data[top_lsb +: img_hw];
	assign old_bot = core_rd_data[bot_lsb +: img_hw];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_en <= '0;
			sof <= 1'b0;
		end else begin
			wr_en <= vld_p3 ? bank_mask : '0;
			sof <= frame_end_p3;
		end
	end

	// the first row ignores whatever the previous frame left in the entry.
	always_ff @(posedge clk) begin
		if (vld_p3) begin
			wr_addr <= x_p3;
			if (first_row_p3) begin
				ent_val <= dark_p3;
				ent_top <= '0;
				ent_bot <= '0;
			end else begin
				ent_val <= old_val || dark_p3;
				ent_top <= (dark_p3 && !old_val) ? y_p3 : old_top;
				ent_bot <= dark_p3 ? y_p3 : old_bot;
			end
		end
	end

	always_comb begin
		wr_data = '0;
		wr_data[val_bit] = ent_val;
		wr_data[top_lsb +: img_hw] = ent_top;
		wr_data[bot_lsb +: img_hw] = ent_bot;
	end

	// edge scan runs over the stored valid bits during the last row only.
	always_ff @(posedge clk) begin
		if (!resetn || !last_row_p3) begin
			lft_done <= 1'b0;
			lft_edge <= '0;
			rt_prev <= 1'b0;
			rt_edge <= '0;
		end else if (vld_p3) begin
			if (!lft_done && old_val) begin
				lft_edge <= x_p3;
			end
			if (!old_val) begin
				lft_done <= 1'b1;
			end
			// a new run starts after any invalid column, and an invalid column marks itself.
			rt_prev <= old_val;
			if (!rt_prev || !old_val) begin
				rt_edge <= x_p3;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			lft_v <= '0;
			rt_v <= '0;
		end else if (sof) begin
			lft_v <= lft_edge;
			rt_v <= rt_edge;
		end
	end

endmodule

//--- source/column_readout.sv
`timescale 1ns/1ns

module column_readout (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       start,
	input  logic [fsa_pkg::bank_w-1:0] bank,
	input  logic [fsa_pkg::img_ww-1:0] column,
	output logic                       host_req,
	output logic [fsa_pkg::bank_w-1:0] host_bank,
	output logic [fsa_pkg::br_aw-1:0]  host_addr,
	input  logic                       host_grant,
	input  logic [fsa_pkg::br_dw-1:0]  host_rd_data,
	output logic                       busy,
	output logic                       data_valid,
	output logic                       entry_valid,
	output logic [fsa_pkg::img_hw-1:0] entry_top,
	output logic [fsa_pkg::img_hw-1:0] entry_bot
);
	import fsa_pkg::*;

	typedef logic [$clog2(rd_latency)-1:0] cnt_t;

	readout_state_t state;
	cnt_t           wait_cnt;
	logic           last_wait;

	assign host_req = (state == st_request);
	assign busy = (state != st_idle);
	assign data_valid = (state == st_done);
	assign last_wait = (wait_cnt == cnt_t'(rd_latency - 1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= st_idle;
			wait_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_request;
					end
				end
				st_request: begin
					if (host_grant) begin
						state <= st_wait;
						wait_cnt <= '0;
					end
				end
				st_wait: begin
					if (last_wait) begin
						state <= st_done;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && start) begin
			host_bank <= bank;
			host_addr <= column;
		end
		// the returned word is on host_rd_data on this last counted cycle.
		if (state == st_wait && last_wait) begin
			entry_valid <= host_rd_data[val_bit];
			entry_top <= host_rd_data[top_lsb +: img_hw];
			entry_bot <= host_rd_data[bot_lsb +: img_hw];
		end
	end

endmodule

//--- source/fsa_top.sv
`timescale 1ns/1ns

module fsa_top (
	input  logic                            clk,
	input  logic                            resetn,
	input  logic                            s_axis_tvalid,
	input  logic [fsa_pkg::pixel_width-1:0] s_axis_tdata,
	input  logic                            s_axis_tuser,
	input  logic                            s_axis_tlast,
	output logic                            s_axis_tready,
	input  logic [fsa_pkg::img_hw-1:0]      height,
	input  logic [fsa_pkg::img_ww-1:0]      width,
	input  logic [fsa_pkg::pixel_width-1:0] ref_data,
	input  logic [fsa_pkg::br_num-1:0]      bank_mask,
	input  logic [fsa_pkg::bank_w-1:0]      scan_bank,
	output logic                            sof,
	output logic [fsa_pkg::img_ww-1:0]      lft_v,
	output logic [fsa_pkg::img_ww-1:0]      rt_v,
	input  logic                            start,
	input  logic [fsa_pkg::bank_w-1:0]      bank,
	input  logic [fsa_pkg::img_ww-1:0]      column,
	output logic                            busy,
	output logic                            data_valid,
	output logic                            entry_valid,
	output logic [fsa_pkg::img_hw-1:0]      entry_top,
	output logic [fsa_pkg::img_hw-1:0]      entry_bot
);
	import fsa_pkg::*;

	logic              core_rd_en;
	logic [br_aw-1:0]  core_rd_addr;
	logic [br_dw-1:0]  core_rd_data;
	logic [br_num-1:0] wr_en;
	logic [br_aw-1:0]  wr_addr;
	logic [br_dw-1:0]  wr_data;
	logic              host_req;
	logic [bank_w-1:0] host_bank;
	logic [br_aw-1:0]  host_addr;
	logic              host_grant;
	logic [br_dw-1:0]  host_rd_data;
	logic              buf_rd_en;
	logic [bank_w-1:0] buf_rd_bank;
	logic [br_aw-1:0]  buf_rd_addr;
	logic [br_dw-1:0]  buf_rd_data;

	fsa_core u_core (
		.clk, .resetn, .height, .width, .bank_mask, .ref_data,
		.s_axis_tvalid, .s_axis_tdata, .s_axis_tuser, .s_axis_tlast, .s_axis_tready,
		.sof, .lft_v, .rt_v,
		.core_rd_en, .core_rd_addr, .wr_en, .wr_addr, .wr_data, .core_rd_data
	);

	column_buffer u_buffer (
		.clk, .wr_en, .wr_addr, .wr_data,
		.buf_rd_en, .buf_rd_bank, .buf_rd_addr, .buf_rd_data
	);

	buffer_read_arbiter u_arbiter (
		.clk, .resetn, .scan_bank,
		.core_rd_en, .core_rd_addr, .host_req, .host_bank, .host_addr,
		.core_rd_data, .host_grant, .host_rd_data,
		.buf_rd_en, .buf_rd_bank, .buf_rd_addr, .buf_rd_data
	);

	column_readout u_readout (
		.clk, .resetn, .start, .bank, .column,
		.host_req, .host_bank, .host_addr, .host_grant, .host_rd_data,
		.busy, .data_valid, .entry_valid, .entry_top, .entry_bot
	);

endmodule

//--- tests/fsa_props.sv
`timescale 1ns/1ns

module fsa_props (
	input logic            clk,
	input logic            resetn,
	input logic            core_rd_en,
	input logic            host_grant,
	input fsa_pkg::owner_t ram_owner,
	input logic            sof
);
	import fsa_pkg::*;

	// the core owns every slot it asks for.
	core_keeps_slot: assert property (@(posedge clk) disable iff (!resetn)
		core_rd_en |-> ##2 (ram_owner == owner_core))
		else $error("core read slot given to the host");

	// a host word leaves the buffer two cycles after its grant, and only then.
	grant_gives_word: assert property (@(posedge clk) disable iff (!resetn)
		host_grant |-> ##2 (ram_owner == owner_host))
		else $error("host grant without a returned word");

	word_has_grant: assert property (@(posedge clk) disable iff (!resetn)
		(ram_owner == owner_host) |-> $past(host_grant, 2))
		else $error("host word returned without a grant");

	sof_single_cycle: assert property (@(posedge clk) disable iff (!resetn)
		sof |=> !sof)
		else $error("sof held for more than one cycle");

endmodule

bind buffer_read_arbiter fsa_props u_arbiter_props (
	.clk, .resetn, .core_rd_en, .host_grant, .ram_owner, .sof(1'b0)
);

bind fsa_core fsa_props u_core_props (
	.clk, .resetn, .core_rd_en(1'b0), .host_grant(1'b0), .ram_owner(fsa_pkg::owner_none), .sof
);

//--- tests/fsa_tb.sv
`timescale 1ns/1ns

module fsa_tb;
	import fsa_pkg::*;

	localparam int frame_w = 16;
	localparam int frame_h = 8;

	logic                   clk;
	logic                   resetn;
	logic                   s_axis_tvalid;
	logic [pixel_width-1:0] s_axis_tdata;
	logic                   s_axis_tuser;
	logic                   s_axis_tlast;
	logic                   s_axis_tready;
	logic [img_hw-1:0]      height;
	logic [img_ww-1:0]      width;
	logic [pixel_width-1:0] ref_data;
	logic [br_num-1:0]      bank_mask;
	logic [bank_w-1:0]      scan_bank;
	logic                   sof;
	logic [img_ww-1:0]      lft_v;
	logic [img_ww-1:0]      rt_v;
	logic                   start;
	logic [bank_w-1:0]      bank;
	logic [img_ww-1:0]      column;
	logic                   busy;
	logic                   data_valid;
	logic                   entry_valid;
	logic [img_hw-1:0]      entry_top;
	logic [img_hw-1:0]      entry_bot;

	logic [31:0] lfsr;
	int          sof_count;
	int          checks;
	int          value_errors;
	int          other_errors;

	// expected column table of every bank, and the edges of the latest frame.
	logic              model_val [br_num][frame_w];
	logic [img_hw-1:0] model_top [br_num][frame_w];
	logic [img_hw-1:0] model_bot [br_num][frame_w];
	logic [img_ww-1:0] exp_lft;
	logic [img_ww-1:0] exp_rt;

	fsa_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		if (resetn && sof) begin
			sof_count++;
		end
	end

	function automatic logic lfsr_next_bit();
		logic out_bit;
		out_bit = lfsr[0];
		lfsr = lfsr >> 1;
		if (out_bit) begin
			lfsr = lfsr ^ 32'h8020_0003;
		end
		return out_bit;
	endfunction

	// kind 0 and 1 are fixed dark shapes and kind 2 is random pixels.
	function automatic logic [pixel_width-1:0] pixel_value(input int kind, input int x,
			input int y);
		logic [pixel_width-1:0] v;
		logic                   dark;
		int                     i;
		v = '0;
		if (kind == 2) begin
			for (i = 0; i < pixel_width; i++) begin
				v = {v[pixel_width-2:0], lfsr_next_bit()};
			end
			return v;
		end
		if (kind == 0) begin
			dark = x >= 4 && x <= 10 && y >= 2 && y <= 5;
		end else begin
			dark = (x <= 5 && y >= 1 && y <= 3) || (x >= 12 && y >= 4 && y <= 6);
		end
		return dark ? 8'h10 : 8'hc0;
	endfunction

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0t ns: %s = %0b, expected %0b", $time, name, got, exp);
		end
	endtask

	task automatic check_column(input string name, input logic [img_ww-1:0] got,
			input logic [img_ww-1:0] exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_entry(input int b, input int c, input logic exp_v,
			input logic [img_hw-1:0] exp_top, input logic [img_hw-1:0] exp_bot);
		check_flag($sformatf("entry_valid bank %0d column %0d", b, c), entry_valid, exp_v);
		checks++;
		if (entry_top !== exp_top) begin
			value_errors++;
			$display("** Error at %0t ns: entry_top bank %0d column %0d = %0d, expected %0d",
				$time, b, c, entry_top, exp_top);
		end
		checks++;
		if (entry_bot !== exp_bot) begin
			value_errors++;
			$display("** Error at %0t ns: entry_bot bank %0d column %0d = %0d, expected %0d",
				$time, b, c, entry_bot, exp_bot);
		end
		if (exp_v) begin
			check_flag("entry_top <= entry_bot", entry_top <= entry_bot, 1'b1);
		end
	endtask

	// streams one frame and updates the model with the column rules.
	task automatic stream_frame(input int kind, input bit gaps);
		logic [pixel_width-1:0] v;
		logic                   dark;
		logic                   f_val [frame_w];
		logic [img_hw-1:0]      f_top [frame_w];
		logic [img_hw-1:0]      f_bot [frame_w];
		logic                   scan_val [frame_w];
		int                     c;
		for (int y = 0; y < frame_h; y++) begin
			for (int x = 0; x < frame_w; x++) begin
				if (gaps && lfsr_next_bit()) begin
					@(posedge clk);
					#1;
					s_axis_tvalid = 1'b0;
				end
				v = pixel_value(kind, x, y);
				dark = v < ref_data;
				@(posedge clk);
				#1;
				s_axis_tvalid = 1'b1;
				s_axis_tdata = v;
				s_axis_tuser = x == 0 && y == 0;
				s_axis_tlast = x == frame_w - 1;
				// the edge scan sees the entries as they stand before the last row.
				if (y == frame_h - 1) begin
					scan_val[x] = f_val[x];
				end
				if (y == 0) begin
					f_val[x] = dark;
					f_top[x] = '0;
					f_bot[x] = '0;
				end else if (dark) begin
					if (!f_val[x]) begin
						f_top[x] = img_hw'(y);
					end
					f_bot[x] = img_hw'(y);
					f_val[x] = 1'b1;
				end
			end
		end
		for (int b = 0; b < br_num; b++) begin
			for (int x = 0; x < frame_w; x++) begin
				if (bank_mask[b]) begin
					model_val[b][x] = f_val[x];
					model_top[b][x] = f_top[x];
					model_bot[b][x] = f_bot[x];
				end
			end
		end
		exp_lft = '0;
		c = 0;
		while (c < frame_w && scan_val[c]) begin
			exp_lft = img_ww'(c);
			c++;
		end
		exp_rt = img_ww'(frame_w - 1);
		if (scan_val[frame_w-1]) begin
			c = frame_w - 1;
			while (c > 0 && scan_val[c-1]) begin
				c--;
			end
			exp_rt = img_ww'(c);
		end
	endtask

	task automatic idle_stream();
		@(posedge clk);
		#1;
		s_axis_tvalid = 1'b0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
	endtask

	task automatic check_frame_end(input int target);
		int cycles;
		cycles = 0;
		while (sof_count < target && cycles < 100) begin
			@(negedge clk);
			cycles++;
		end
		if (sof_count < target) begin
			other_errors++;
			$display("timeout: sof did not pulse within 100 cycles of the frame end");
		end
		check_column("lft_v", lft_v, exp_lft);
		check_column("rt_v", rt_v, exp_rt);
		repeat (3) @(negedge clk);
		if (sof_count != target) begin
			other_errors++;
			$display("expected %0d sof pulses so far but counted %0d", target, sof_count);
		end
	endtask

	task automatic read_column(input int b, input int c);
		int cycles;
		cycles = 0;
		while (busy && cycles < 50) begin
			@(negedge clk);
			cycles++;
		end
		if (busy) begin
			other_errors++;
			$display("timeout: readout stayed busy before reading column %0d", c);
		end
		@(posedge clk);
		#1;
		start = 1'b1;
		bank = bank_w'(b);
		column = img_ww'(c);
		@(posedge clk);
		#1;
		start = 1'b0;
		cycles = 0;
		@(negedge clk);
		while (!data_valid && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		if (!data_valid) begin
			other_errors++;
			$display("timeout: readout of bank %0d column %0d never finished", b, c);
		end else begin
			check_entry(b, c, model_val[b][c], model_top[b][c], model_bot[b][c]);
		end
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		check_flag("sof", sof, 1'b0);
		check_flag("busy", busy, 1'b0);
		check_flag("data_valid", data_valid, 1'b0);
		check_flag("s_axis_tready", s_axis_tready, 1'b1);
		check_column("lft_v", lft_v, '0);
		check_column("rt_v", rt_v, '0);
	endtask

	task automatic run_rect_frame();
		int target;
		target = sof_count + 1;
		stream_frame(0, 1'b0);
		idle_stream();
		check_frame_end(target);
	endtask

	task automatic read_rect_columns();
		for (int c = 0; c < frame_w; c += 3) begin
			read_column(0, c);
		end
		read_column(0, 4);
		read_column(0, 10);
		read_column(0, 11);
		read_column(3, 7);
	endtask

	// bank 1 takes a random frame while the host reads the rectangle from bank 0.
	task automatic read_during_stream();
		int target;
		@(posedge clk);
		#1;
		bank_mask = 4'b0010;
		scan_bank = 2'd1;
		target = sof_count + 1;
		fork
			begin
				stream_frame(2, 1'b1);
				idle_stream();
			end
			for (int c = 0; c < frame_w; c += 3) begin
				read_column(0, c);
			end
		join
		check_frame_end(target);
		for (int c = 0; c < frame_w; c++) begin
			read_column(1, c);
		end
		read_column(0, 7);
		read_column(2, 4);
		read_column(2, 11);
	endtask

	task automatic run_back_to_back();
		int target;
		@(posedge clk);
		#1;
		bank_mask = '1;
		scan_bank = '0;
		target = sof_count + 2;
		stream_frame(0, 1'b0);
		stream_frame(1, 1'b0);
		idle_stream();
		check_frame_end(target);
		for (int c = 0; c < frame_w; c += 2) begin
			read_column(0, c);
		end
		read_column(1, 5);
		read_column(3, 12);
	endtask

	initial begin
		lfsr = 32'hcd3a_dbf1;
		sof_count = 0;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		resetn = 1'b0;
		s_axis_tvalid = 1'b0;
		s_axis_tdata = '0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		height = img_hw'(frame_h);
		width = img_ww'(frame_w);
		ref_data = 8'h40;
		bank_mask = '1;
		scan_bank = '0;
		start = 1'b0;
		bank = '0;
		column = '0;
		repeat (5) @(posedge clk);
		#1;
		resetn = 1'b1;
		check_reset_state();
		run_rect_frame();
		read_rect_columns();
		read_during_stream();
		run_back_to_back();
		$display("checks: %0d, value errors: %0d, other failures: %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
source/fsa_pkg.sv
source/column_buffer.sv
source/buffer_read_arbiter.sv
source/fsa_core.sv
source/column_readout.sv
source/fsa_top.sv
tests/fsa_props.sv
tests/fsa_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fsa_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
